//--- source/arb_cfg.svh
/*
 * stream arbiter configuration
 * producer count, payload width and source index width
 */
`ifndef ARB_CFG_SVH
`define ARB_CFG_SVH

// number of producer streams merged into the output
`define ARB_NUM_REQS 4

// payload bits per item
`define ARB_DATA_W 16

// index of the winning input, at least one bit
`define ARB_SEL_W ((`ARB_NUM_REQS > 1) ? $clog2(`ARB_NUM_REQS) : 1)

`endif

//--- source/arb_pkg.sv
/*
 * stream arbiter types
 * payload, source index, request vector and buffer occupancy
 */
`default_nettype none
`include "arb_cfg.svh"

package arb_pkg;

    typedef logic [`ARB_DATA_W-1:0]   data_t;
    typedef logic [`ARB_SEL_W-1:0]    sel_t;
    typedef logic [`ARB_NUM_REQS-1:0] req_vec_t;

    // occupancy of the output skid buffer
    typedef enum logic [1:0] {
        EMPTY = 2'd0,
        ONE   = 2'd1,
        TWO   = 2'd2
    } buf_state_t;

endpackage

`default_nettype wire

//--- source/stream_if.sv
/*
 * stream interface
 * one valid/ready stream with payload and source index
 */
`timescale 1ns/10ps
`default_nettype none
`include "arb_cfg.svh"

interface stream_if;

    logic           valid;
    arb_pkg::data_t data;
    arb_pkg::sel_t  sel;
    logic           ready;

    modport producer (
        output valid,
        output data,
        output sel,
        input  ready
    );

    modport consumer (
        input  valid,
        input  data,
        input  sel,
        output ready
    );

endinterface

`default_nettype wire

//--- source/rr_arbiter.sv
/*
 * round-robin arbiter
 * grant is locked until unlock, then priority moves past the winner
 */
`timescale 1ns/10ps
`default_nettype none
`include "arb_cfg.svh"

module rr_arbiter (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire arb_pkg::req_vec_t   requests,
    input  wire                      unlock,
    output logic                     grant_valid,
    output arb_pkg::sel_t            grant_index,
    output arb_pkg::req_vec_t        grant_onehot
);

    arb_pkg::sel_t pointer;
    arb_pkg::sel_t lock_index;
    logic          locked;
    logic          pick_valid;
    arb_pkg::sel_t pick_index;

    // first requester at or after the pointer
    always_comb begin : pick_rr
        int cand;
        pick_valid = 1'b0;
        pick_index = '0;
        for (int i = 0; i < `ARB_NUM_REQS; i++) begin
            cand = (int'(pointer) + i) % `ARB_NUM_REQS;
            if (!pick_valid && requests[cand]) begin
                pick_valid = 1'b1;
                pick_index = arb_pkg::sel_t'(cand);
            end
        end
    end

    assign grant_valid = locked || pick_valid;
    assign grant_index = locked ? lock_index : pick_index;

    always_comb begin
        for (int i = 0; i < `ARB_NUM_REQS; i++) begin
            grant_onehot[i] = grant_valid && (grant_index == arb_pkg::sel_t'(i));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pointer    <= '0;
            locked     <= 1'b0;
            lock_index <= '0;
        end else if (unlock) begin
            locked  <= 1'b0;
            pointer <= (grant_index == arb_pkg::sel_t'(`ARB_NUM_REQS - 1)) ?
                       '0 : grant_index + 1'b1;
        end else if (grant_valid && !locked) begin
            locked     <= 1'b1;
            lock_index <= pick_index;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        grant_valid |-> $onehot(grant_onehot));

    // producer must keep valid up while its grant is held
    assert property (@(posedge clk) disable iff (!arst_n)
        locked |-> requests[lock_index]);

endmodule

`default_nettype wire

//--- source/stream_select.sv
/*
 * stream selector
 * forwards the granted input and returns ready only to it
 */
`timescale 1ns/10ps
`default_nettype none
`include "arb_cfg.svh"

module stream_select (
    input  wire                                       clk,
    input  wire                                       arst_n,
    input  wire arb_pkg::req_vec_t                    valid_in,
    input  wire arb_pkg::data_t [`ARB_NUM_REQS-1:0]   data_in,
    output arb_pkg::req_vec_t                         ready_in,
    stream_if.producer                                out
);

    logic              grant_valid;
    arb_pkg::sel_t     grant_index;
    arb_pkg::req_vec_t grant_onehot;
    logic              unlock;

    rr_arbiter arbiter (
        .clk          (clk),
        .arst_n       (arst_n),
        .requests     (valid_in),
        .unlock       (unlock),
        .grant_valid  (grant_valid),
        .grant_index  (grant_index),
        .grant_onehot (grant_onehot)
    );

    assign out.valid = grant_valid;
    assign out.data  = data_in[grant_index];
    assign out.sel   = grant_index;

    // lock ends when the winner is taken by the buffer
    assign unlock = grant_valid && out.ready;

    assign ready_in = grant_onehot & {`ARB_NUM_REQS{out.ready}};

endmodule

`default_nettype wire

//--- source/elastic_buffer.sv
/*
 * two-entry elastic buffer
 * registered output and input ready, full rate under steady flow
 */
`timescale 1ns/10ps
`default_nettype none
`include "arb_cfg.svh"

module elastic_buffer (
    input  wire                 clk,
    input  wire                 arst_n,
    stream_if.consumer          in,
    output logic                valid_out,
    output arb_pkg::data_t      data_out,
    output arb_pkg::sel_t       sel_out,
    input  wire                 ready_out
);

    arb_pkg::buf_state_t state;
    arb_pkg::data_t      main_data;
    arb_pkg::sel_t       main_sel;
    arb_pkg::data_t      skid_data;
    arb_pkg::sel_t       skid_sel;
    logic                push;
    logic                pop;

    // both flags come straight from the state register
    assign in.ready  = (state != arb_pkg::TWO);
    assign valid_out = (state != arb_pkg::EMPTY);

    assign push = in.valid && in.ready;
    assign pop  = valid_out && ready_out;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= arb_pkg::EMPTY;
        end else begin
            case (state)
                arb_pkg::EMPTY: if (push) state <= arb_pkg::ONE;
                arb_pkg::ONE: begin
                    if (push && !pop) begin
                        state <= arb_pkg::TWO;
                    end else if (!push && pop) begin
                        state <= arb_pkg::EMPTY;
                    end
                end
                arb_pkg::TWO: if (pop) state <= arb_pkg::ONE;
                default: state <= arb_pkg::EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && (state == arb_pkg::ONE) && !pop) begin
            // main is stalled, park the new item
            skid_data <= in.data;
            skid_sel  <= in.sel;
        end else if (push) begin
            main_data <= in.data;
            main_sel  <= in.sel;
        end else if (pop && (state == arb_pkg::TWO)) begin
            main_data <= skid_data;
            main_sel  <= skid_sel;
        end
    end

    assign data_out = main_data;
    assign sel_out  = main_sel;

    assert property (@(posedge clk) disable iff (!arst_n)
        valid_out && !ready_out |=> $stable(data_out) && $stable(sel_out));

endmodule

`default_nettype wire

//--- source/stream_arb_top.sv
/*
 * many-to-one stream arbiter
 * round-robin merge of the producer streams into one buffered output
 */
`timescale 1ns/10ps
`default_nettype none
`include "arb_cfg.svh"

module stream_arb_top (
    input  wire                                       clk,
    input  wire                                       arst_n,

    input  wire arb_pkg::req_vec_t                    valid_in,
    input  wire arb_pkg::data_t [`ARB_NUM_REQS-1:0]   data_in,
    output wire arb_pkg::req_vec_t                    ready_in,

    output wire                                       valid_out,
    output wire arb_pkg::data_t                       data_out,
    output wire arb_pkg::sel_t                        sel_out,
    input  wire                                       ready_out
);

    // selected item on its way into the output buffer
    stream_if sel_to_buf ();

    stream_select select (
        .clk      (clk),
        .arst_n   (arst_n),
        .valid_in (valid_in),
        .data_in  (data_in),
        .ready_in (ready_in),
        .out      (sel_to_buf.producer)
    );

    elastic_buffer out_buf (
        .clk       (clk),
        .arst_n    (arst_n),
        .in        (sel_to_buf.consumer),
        .valid_out (valid_out),
        .data_out  (data_out),
        .sel_out   (sel_out),
        .ready_out (ready_out)
    );

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
/*
 * testbench clock and reset
 * free-running clock, reset held low over the first rising edges
 */
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter int period       = 100,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        arst_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/stream_arb_tb.sv
/*
 * stream arbiter testbench
 * directed tests against a per-input scoreboard, with a watchdog
 */
`timescale 1ns/10ps
`default_nettype none
`include "arb_cfg.svh"

module stream_arb_tb;

    localparam int clk_period   = 100;
    localparam int num_reqs     = `ARB_NUM_REQS;
    localparam int reset_len    = 8;
    localparam int rr_len       = 30;
    localparam int single_len   = 30;
    localparam int hold_len     = 6;
    localparam int random_len   = 300;
    localparam int drain_len    = 40;
    localparam int total_cycles = reset_len + rr_len + single_len + hold_len
                                + random_len + 4 * drain_len;

    wire                                clk;
    wire                                arst_n;
    arb_pkg::req_vec_t                  valid_in;
    arb_pkg::data_t [num_reqs-1:0]      data_in;
    wire arb_pkg::req_vec_t             ready_in;
    wire                                valid_out;
    wire arb_pkg::data_t                data_out;
    wire arb_pkg::sel_t                 sel_out;
    logic                               ready_out;

    // accepted items per input, oldest first
    arb_pkg::data_t expect_q [num_reqs][$];
    arb_pkg::data_t last_taken [num_reqs];
    int             quota [num_reqs];
    int             item_seq [num_reqs];
    int             next_priority;
    int             accepted_count;
    int             delivered_count;
    int             error_count;
    integer         seed;
    string          test_name;

    clock_gen #(.period(clk_period), .reset_cycles(2)) clocks (
        .clk    (clk),
        .arst_n (arst_n)
    );

    stream_arb_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (valid_in),
        .data_in   (data_in),
        .ready_in  (ready_in),
        .valid_out (valid_out),
        .data_out  (data_out),
        .sel_out   (sel_out),
        .ready_out (ready_out)
    );

    task automatic check_eq(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            error_count++;
            $display("** Error [%s] %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic note_failure(input string msg);
        error_count++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    function automatic bit outputs_idle();
        bit idle;
        idle = (valid_in == '0) && !valid_out;
        for (int i = 0; i < num_reqs; i++) begin
            if (expect_q[i].size() != 0) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    // one clock of every producer, a waiting item stays until it is taken
    task automatic step_producers(input arb_pkg::req_vec_t want, input logic ready,
                                  output arb_pkg::req_vec_t taken);
        @(posedge clk);
        taken = valid_in & ready_in;
        ready_out <= ready;
        for (int i = 0; i < num_reqs; i++) begin
            if (taken[i]) begin
                last_taken[i] = data_in[i];
            end
            if (!valid_in[i] || taken[i]) begin
                if (want[i] && quota[i] > 0) begin
                    valid_in[i] <= 1'b1;
                    data_in[i]  <= arb_pkg::data_t'(i * 4096 + item_seq[i] % 4096);
                    item_seq[i]++;
                    quota[i]--;
                end else begin
                    valid_in[i] <= 1'b0;
                end
            end
        end
    endtask

    task automatic drain_outputs();
        arb_pkg::req_vec_t taken;
        int cycles;
        cycles = 0;
        do begin
            step_producers('0, 1'b1, taken);
            @(negedge clk);
            cycles++;
        end while (!outputs_idle() && cycles < drain_len);
        assert (outputs_idle()) else
            note_failure($sformatf("items still pending %0d cycles after the inputs stopped",
                                   cycles));
    endtask

    task automatic reset_state();
        arb_pkg::req_vec_t taken;
        int cycles;
        test_name = "reset_state";
        cycles = 0;
        do begin
            @(negedge clk);
            check_eq("valid_out", 0, int'(valid_out));
            check_eq("ready_in", 0, int'(ready_in));
            cycles++;
        end while (!arst_n && cycles < reset_len);
        assert (arst_n) else note_failure("reset was never released");
        repeat (2) begin
            step_producers('0, 1'b1, taken);
            @(negedge clk);
            check_eq("valid_out after reset", 0, int'(valid_out));
            check_eq("ready_in after reset", 0, int'(ready_in));
        end
    endtask

    task automatic round_robin_order();
        arb_pkg::req_vec_t taken;
        int start;
        int count;
        int cycles;
        test_name = "round_robin_order";
        start = next_priority;
        count = 0;
        cycles = 0;
        for (int i = 0; i < num_reqs; i++) begin
            quota[i] = 2;
        end
        while (count < 2 * num_reqs && cycles < rr_len) begin
            step_producers('1, 1'b1, taken);
            @(negedge clk);
            cycles++;
            if (valid_out && ready_out) begin
                check_eq("sel_out", (start + count) % num_reqs, int'(sel_out));
                count++;
            end
        end
        assert (count == 2 * num_reqs) else
            note_failure($sformatf("only %0d items came out in %0d cycles", count, cycles));
        drain_outputs();
    endtask

    task automatic single_source();
        arb_pkg::req_vec_t taken;
        int sent;
        int cycles;
        test_name = "single_source";
        for (int i = 0; i < num_reqs; i++) begin
            quota[i] = 0;
        end
        quota[2] = 5;
        sent = 0;
        cycles = 0;
        while (sent < 5 && cycles < single_len) begin
            step_producers('1, 1'b1, taken);
            cycles++;
            if (taken[2]) begin
                // output register shows the item one cycle after its transfer
                @(negedge clk);
                check_eq("valid_out", 1, int'(valid_out));
                check_eq("sel_out", 2, int'(sel_out));
                check_eq("data_out", int'(last_taken[2]), int'(data_out));
                sent++;
            end
        end
        assert (sent == 5) else
            note_failure($sformatf("only %0d of 5 items were accepted", sent));
        drain_outputs();
    endtask

    task automatic back_pressure_hold();
        arb_pkg::req_vec_t taken;
        arb_pkg::data_t held_data;
        int held_sel;
        bit holding;
        int hold_taken;
        test_name = "back_pressure_hold";
        for (int i = 0; i < num_reqs; i++) begin
            quota[i] = 3;
        end
        holding = 1'b0;
        hold_taken = 0;
        held_data = '0;
        held_sel = 0;
        repeat (hold_len) begin
            step_producers('1, 1'b0, taken);
            hold_taken += $countones(taken);
            // first accepted item reaches the output and stays there
            if (!holding && taken != '0) begin
                holding = 1'b1;
                for (int i = 0; i < num_reqs; i++) begin
                    if (taken[i]) begin
                        held_data = last_taken[i];
                        held_sel = i;
                    end
                end
            end
            @(negedge clk);
            if (holding) begin
                check_eq("valid_out while stalled", 1, int'(valid_out));
                check_eq("data_out while stalled", int'(held_data), int'(data_out));
                check_eq("sel_out while stalled", held_sel, int'(sel_out));
            end
        end
        // main and skid entries, then nothing more
        check_eq("items accepted while stalled", 2, hold_taken);
        check_eq("ready_in while stalled", 0, int'(ready_in));
        drain_outputs();
    endtask

    task automatic random_traffic();
        arb_pkg::req_vec_t taken;
        int rnd;
        test_name = "random_traffic";
        for (int i = 0; i < num_reqs; i++) begin
            quota[i] = random_len;
        end
        repeat (random_len) begin
            rnd = $random(seed);
            step_producers(arb_pkg::req_vec_t'(rnd), rnd[8], taken);
        end
        drain_outputs();
        check_eq("items delivered", accepted_count, delivered_count);
    endtask

    always @(posedge clk) begin : scoreboard
        arb_pkg::data_t expected;
        int src;
        if (arst_n) begin
            for (int i = 0; i < num_reqs; i++) begin
                if (valid_in[i] && ready_in[i]) begin
                    expect_q[i].push_back(data_in[i]);
                    accepted_count++;
                    // priority moves one past the last winner
                    next_priority = (i + 1) % num_reqs;
                end
            end
            if (valid_out && ready_out) begin
                src = int'(sel_out);
                delivered_count++;
                assert (expect_q[src].size() > 0) else
                    note_failure($sformatf("input %0d delivered %h that was never accepted",
                                           src, data_out));
                if (expect_q[src].size() > 0) begin
                    expected = expect_q[src].pop_front();
                    check_eq("data_out", int'(expected), int'(data_out));
                end
            end
        end
    end

    initial begin : watchdog
        #(total_cycles * 4 * clk_period);
        $display("watchdog expired, the tests did not finish within %0d cycles",
                 total_cycles * 4);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        valid_in  <= '0;
        data_in   <= '0;
        ready_out <= 1'b0;
        seed = 32'hdb82d722;
        next_priority = 0;
        accepted_count = 0;
        delivered_count = 0;
        error_count = 0;
        for (int i = 0; i < num_reqs; i++) begin
            quota[i] = 0;
            item_seq[i] = 0;
        end
        reset_state();
        round_robin_order();
        single_source();
        back_pressure_hold();
        random_traffic();
        $display("errors: %0d, items accepted: %0d, items delivered: %0d",
                 error_count, accepted_count, delivered_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+source
source/arb_pkg.sv
source/stream_if.sv
source/rr_arbiter.sv
source/stream_select.sv
source/elastic_buffer.sv
source/stream_arb_top.sv
bench/clock_gen.sv
bench/stream_arb_tb.sv

//--- Makefile
# Verilator build and run of the stream arbiter testbench

SRCS := $(wildcard source/*.sv source/*.svh bench/*.sv)

obj_dir/Vstream_arb_tb: list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f list.f --top-module stream_arb_tb

run: obj_dir/Vstream_arb_tb
	./obj_dir/Vstream_arb_tb > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
